/* dv/memStim.txt */
# name op addr(hex) len word(hex) stall order
# op F fetch, L load, S store, B fetch and load together; word is stored or expected
# for B the word is the full word at addr, the load expects it zero-extended to len
st4a  S 00100 4 a1b2c3d4 0 0
ld4a  L 00100 4 a1b2c3d4 0 0
ld2a  L 00100 2 0000c3d4 0 0
ld1a  L 00100 1 000000d4 0 0
fe4a  F 00100 4 a1b2c3d4 0 0
st4b  S 00200 4 55667788 0 0
st2b  S 00202 2 0000abcd 0 0
ld4b  L 00200 4 abcd7788 0 0
st1b  S 00201 1 000000ee 0 0
ld4c  L 00200 4 abcdee88 0 0
ld2c  L 00201 2 0000cdee 0 0
fe4b  F 00200 4 abcdee88 0 0
st4h  S 1fff0 4 0badf00d 0 0
ld4h  L 1fff0 4 0badf00d 0 0
both1 B 00100 4 a1b2c3d4 0 1
both2 B 00200 2 abcdee88 0 1
both3 B 00100 1 a1b2c3d4 0 1
st4s  S 00300 4 deadbeef 1 0
ld4s  L 00300 4 deadbeef 1 0
st4u  S 00304 4 01020304 1 0
st2s  S 00304 2 00001357 1 0
st1s  S 00306 1 0000009a 1 0
ld4u  L 00304 4 019a1357 1 0
ld2s  L 00306 2 0000019a 1 0
fe4s  F 00300 4 deadbeef 1 0
both4 B 00304 4 019a1357 1 1
both5 B 00300 2 deadbeef 1 1
ld4f  L 00304 4 019a1357 0 0

/* dv/memSubsystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;
    import memPkg::*;

    localparam int CLK_HALF   = 10;
    localparam int DRIVE_DLY  = 2;
    localparam int WAIT_LIMIT = 100;

    logic              clk;
    logic              rst;
    logic              ioBufferFull;
    logic              fetchEn;
    logic [ADDR_W-1:0] fetchAddr;
    logic              dataEn;
    logic              dataStore;
    memLen_e           dataLen;
    logic [ADDR_W-1:0] dataAddr;
    logic [31:0]       dataWrite;
    logic              fetchDone;
    logic [31:0]       fetchInst;
    logic              dataDone;
    logic [31:0]       dataRead;

    int errCount;
    int testCount;
    int failCount;
    int stallLeft;
    bit stallMode;
    bit timedOutAny;

    memSubsystem DUT (
        .clk            (clk),
        .rst            (rst),
        .i_ioBufferFull (ioBufferFull),
        .i_fetchEn      (fetchEn),
        .i_fetchAddr    (fetchAddr),
        .i_dataEn       (dataEn),
        .i_dataStore    (dataStore),
        .i_dataLen      (dataLen),
        .i_dataAddr     (dataAddr),
        .i_dataWrite    (dataWrite),
        .o_fetchDone    (fetchDone),
        .o_fetchInst    (fetchInst),
        .o_dataDone     (dataDone),
        .o_dataRead     (dataRead)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic checkValue(input string sigName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h, got %h", $time, sigName, expected, actual);
            errCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testCount++;
        if (errCount == errBefore) begin
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: failed with %0d errors", name, errCount - errBefore);
        end
    endtask

    // move to the drive point of the next cycle with random back-pressure in stall mode
    task automatic nextCycle();
        @(posedge clk);
        #DRIVE_DLY;
        if (!stallMode) begin
            ioBufferFull = 1'b0;
        end else if (stallLeft > 0) begin
            ioBufferFull = 1'b1;
            stallLeft--;
        end else if ($urandom_range(3, 0) == 0) begin
            ioBufferFull = 1'b1;
            stallLeft    = $urandom_range(2, 0);
        end else begin
            ioBufferFull = 1'b0;
        end
    endtask

    // returns in the done cycle with cycles counted from the raised request
    task automatic waitForDone(inout int cycles, output bit sawFetch, output bit sawData,
                               output bit timedOut);
        int n;
        n        = 0;
        sawFetch = 1'b0;
        sawData  = 1'b0;
        timedOut = 1'b0;
        while (!sawFetch && !sawData && !timedOut) begin
            @(negedge clk);
            if (ioBufferFull && (fetchDone || dataDone)) begin
                $display("error at %0t: done raised while the IO buffer is full", $time);
                errCount++;
            end
            if (fetchDone || dataDone) begin
                sawFetch = fetchDone;
                sawData  = dataDone;
            end else if (n == WAIT_LIMIT) begin
                timedOut = 1'b1;
            end else begin
                nextCycle();
                cycles++;
                n++;
            end
        end
    endtask

    function automatic logic [31:0] zeroExtend(input logic [31:0] value, input int len);
        return (len >= 4) ? value : value & ((32'd1 << (8 * len)) - 32'd1);
    endfunction

    task automatic noteTimeout(input string name);
        $display("test %s: timeout, no done within %0d cycles", name, WAIT_LIMIT);
        timedOutAny = 1'b1;
        errCount++;
    endtask

    task automatic runTest(input string name, input string op, input logic [ADDR_W-1:0] addr,
                           input int len, input logic [31:0] word, input bit stall,
                           input bit dataFirst);
        int errBefore;
        int cycles;
        bit sawFetch;
        bit sawData;
        bit timedOut;
        errBefore = errCount;
        cycles    = 0;
        sawFetch  = 1'b0;
        sawData   = 1'b0;
        timedOut  = 1'b0;
        stallMode = stall;
        stallLeft = 0;
        nextCycle();
        fetchAddr = addr;
        dataAddr  = addr;
        dataLen   = memLen_e'(len[2:0]);
        dataWrite = word;
        dataStore = (op == "S");
        fetchEn   = (op == "F" || op == "B");
        dataEn    = (op == "L" || op == "S" || op == "B");
        if (!fetchEn && !dataEn) begin
            $display("test %s: unknown operation %s", name, op);
            errCount++;
        end else begin
            waitForDone(cycles, sawFetch, sawData, timedOut);
        end
        if (timedOut) begin
            noteTimeout(name);
        end else if (op != "B" && (fetchEn || dataEn)) begin
            if (sawFetch != fetchEn || sawData != dataEn) begin
                $display("test %s: done came from the wrong client", name);
                errCount++;
            end
            if (op == "F") begin
                checkValue("o_fetchInst", word, fetchInst);
            end else if (op == "L") begin
                checkValue("o_dataRead", word, dataRead);
            end
            // reads finish at L+2, stores at L+1
            if (!stall) begin
                checkValue("done latency", 32'(len + ((op == "S") ? 1 : 2)), 32'(cycles));
            end
        end else if (op == "B") begin
            if (sawData != dataFirst) begin
                $display("test %s: done order differs from the expected order", name);
                errCount++;
            end else if (!sawData) begin
                checkValue("o_fetchInst", word, fetchInst);
            end else begin
                checkValue("o_dataRead", zeroExtend(word, len), dataRead);
                if (!stall) begin
                    checkValue("load latency", 32'(len + 2), 32'(cycles));
                end
                nextCycle();
                cycles++;
                dataEn = 1'b0;
                waitForDone(cycles, sawFetch, sawData, timedOut);
                if (timedOut) begin
                    noteTimeout(name);
                end else if (sawData) begin
                    $display("test %s: data done raised twice", name);
                    errCount++;
                end else begin
                    checkValue("o_fetchInst", word, fetchInst);
                    // fetch starts the cycle after data done and takes 6 more
                    if (!stall) begin
                        checkValue("fetch latency", 32'(len + 9), 32'(cycles));
                    end
                end
            end
        end
        stallMode = 1'b0;
        nextCycle();
        fetchEn   = 1'b0;
        dataEn    = 1'b0;
        dataStore = 1'b0;
        reportTest(name, errBefore);
    endtask

    initial begin
        string       line;
        string       name;
        string       op;
        int          fd;
        int          nItems;
        int          lenVal;
        int          stallVal;
        int          orderVal;
        int          idleErr;
        logic [31:0] addrVal;
        logic [31:0] wordVal;
        errCount     = 0;
        testCount    = 0;
        failCount    = 0;
        stallLeft    = 0;
        stallMode    = 1'b0;
        timedOutAny  = 1'b0;
        void'($urandom(32'h2805));
        rst          = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        dataEn       = 1'b0;
        dataStore    = 1'b0;
        dataLen      = ONE;
        dataAddr     = '0;
        dataWrite    = '0;
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        // no enables, so nothing may finish
        idleErr = errCount;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            checkValue("o_fetchDone", 32'd0, 32'(fetchDone));
            checkValue("o_dataDone", 32'd0, 32'(dataDone));
            nextCycle();
        end
        reportTest("idle", idleErr);

        fd = $fopen("dv/memStim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file dv/memStim.txt");
            errCount++;
        end else begin
            while (!timedOutAny && !$feof(fd)) begin
                nItems = $fgets(line, fd);
                if (nItems == 0 || line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                nItems = $sscanf(line, "%s %s %h %d %h %d %d", name, op, addrVal, lenVal,
                                 wordVal, stallVal, orderVal);
                if (nItems != 7) begin
                    $display("stimulus line could not be parsed: %s", line);
                    errCount++;
                    continue;
                end
                runTest(name, op, addrVal[ADDR_W-1:0], lenVal, wordVal, stallVal != 0,
                        orderVal != 0);
            end
            $fclose(fd);
        end

        $display("tests run %0d, failed %0d, errors %0d", testCount, failCount, errCount);
        if (errCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/byteAssembler.sv */
`timescale 1ns/1ps
`default_nettype none

module byteAssembler (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_accept,
    input  logic        i_step,
    input  logic [1:0]  i_byteIdx,
    ramPortIf.mon       port,
    output logic [31:0] o_word
);
    import memPkg::*;

    logic     stepD;
    logic [1:0] idxD;
    memWord_u word;

    // tracks the one-cycle RAM read latency
    always_ff @(posedge clk) begin
        if (rst) begin
            stepD <= 1'b0;
        end else begin
            stepD <= i_step;
        end
    end

    always_ff @(posedge clk) begin
        idxD <= i_byteIdx;
    end

    // unused lanes stay zero, which gives the zero extension
    always_ff @(posedge clk) begin
        if (i_accept) begin
            word.word <= '0;
        end else if (stepD) begin
            word.lanes[idxD] <= port.rdData;
        end
    end

    assign o_word = word.word;

    // a new request never lands on a byte still in flight
    noAcceptDuringCapture: assert property (
        @(posedge clk) disable iff (rst)
        i_accept |-> !stepD
    );

endmodule

`default_nettype wire

/* hw/byteRam.sv */
`timescale 1ns/1ps
`default_nettype none

module byteRam (
    input  logic  clk,
    ramPortIf.ram port
);
    import memPkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    logic [7:0] mem [DEPTH];

    // read returns the old byte on a same-address write
    always_ff @(posedge clk) begin
        if (port.wrEn) begin
            mem[port.addr] <= port.wrData;
        end
        port.rdData <= mem[port.addr];
    end

endmodule

`default_nettype wire

/* hw/byteSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module byteSequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_accept,
    input  memPkg::memKind_e          i_kind,
    input  logic                      i_step,
    input  logic [1:0]                i_byteIdx,
    input  logic [memPkg::ADDR_W-1:0] i_fetchAddr,
    input  logic [memPkg::ADDR_W-1:0] i_dataAddr,
    input  logic [31:0]               i_storeData,
    ramPortIf.seq                     port
);
    import memPkg::*;

    logic [ADDR_W-1:0] baseAddr;
    logic [ADDR_W-1:0] stepAddr;
    logic [ADDR_W-1:0] lastAddr;
    memWord_u          storeWord;

    always_ff @(posedge clk) begin
        if (i_accept) begin
            baseAddr <= (i_kind == FETCH) ? i_fetchAddr : i_dataAddr;
            if (i_kind == STORE) begin
                storeWord.word <= i_storeData;
            end
        end
    end

    assign stepAddr = baseAddr + ADDR_W'(i_byteIdx);

    // keep the last issued address so a stalled RAM re-reads the same byte
    always_ff @(posedge clk) begin
        if (rst) begin
            lastAddr <= '0;
        end else if (i_step) begin
            lastAddr <= stepAddr;
        end
    end

    assign port.addr   = i_step ? stepAddr : lastAddr;
    assign port.wrEn   = i_step && (i_kind == STORE);
    assign port.wrData = storeWord.lanes[i_byteIdx];

    // writes only happen on issued bytes
    wrOnlyOnStep: assert property (
        @(posedge clk) disable iff (rst)
        port.wrEn |-> i_step
    );

endmodule

`default_nettype wire

/* hw/memArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_ioBufferFull,
    input  logic              i_fetchEn,
    input  logic              i_dataEn,
    input  logic              i_dataStore,
    input  memPkg::memLen_e   i_dataLen,
    output logic              o_accept,
    output memPkg::memKind_e  o_kind,
    output logic              o_step,
    output logic [1:0]        o_byteIdx,
    output logic              o_fetchDone,
    output logic              o_dataDone
);
    import memPkg::*;

    memKind_e           kindQ;
    memKind_e           grantKind;
    memLen_e            lenQ;
    memLen_e            grantLen;
    logic [STAGE_W-1:0] stage;
    logic [STAGE_W-1:0] doneStage;
    logic               busy;
    logic               finish;

    assign busy = (kindQ != IDLE);

    // data side has priority over fetch
    always_comb begin
        if (i_dataEn) begin
            grantKind = i_dataStore ? STORE : LOAD;
            grantLen  = i_dataLen;
        end else begin
            grantKind = FETCH;
            grantLen  = FETCH_LEN;
        end
    end

    assign o_accept = !busy && !i_ioBufferFull && (i_fetchEn || i_dataEn);

    // datapaths see the granted kind in the accept cycle
    assign o_kind = o_accept ? grantKind : kindQ;

    // one byte per stage until the length is used up
    assign o_step    = busy && !i_ioBufferFull && (stage < STAGE_W'(lenQ));
    assign o_byteIdx = stage[1:0];

    // stores end right after the last write, reads wait for the RAM latency
    always_comb begin
        if (kindQ == STORE) begin
            doneStage = STAGE_W'(lenQ);
        end else begin
            doneStage = STAGE_W'(lenQ) + STAGE_W'(1);
        end
    end

    assign finish      = busy && !i_ioBufferFull && (stage == doneStage);
    assign o_fetchDone = finish && (kindQ == FETCH);
    assign o_dataDone  = finish && (kindQ != FETCH);

    always_ff @(posedge clk) begin
        if (rst) begin
            kindQ <= IDLE;
            lenQ  <= FOUR;
            stage <= '0;
        end else if (!i_ioBufferFull) begin
            if (o_accept) begin
                kindQ <= grantKind;
                lenQ  <= grantLen;
                stage <= '0;
            end else if (finish) begin
                kindQ <= IDLE;
                stage <= '0;
            end else if (busy) begin
                stage <= stage + STAGE_W'(1);
            end
        end
    end

    // clients are served one at a time
    doneExclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(o_fetchDone && o_dataDone)
    );

    // no byte may be issued during back-pressure
    noStepWhileFull: assert property (
        @(posedge clk) disable iff (rst)
        i_ioBufferFull |-> !o_step
    );

endmodule

`default_nettype wire

/* hw/memPkg.sv */
`default_nettype none

package memPkg;

    // byte address into the RAM
    localparam int ADDR_W = 17;

    // stage counter covers L+1 for a four-byte read
    localparam int STAGE_W = 3;

    // access length, encoded as the byte count
    typedef enum logic [2:0] {
        ONE  = 3'd1,
        TWO  = 3'd2,
        FOUR = 3'd4
    } memLen_e;

    // what the controller is currently serving
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        LOAD,
        STORE
    } memKind_e;

    // instruction fetch always moves a full word
    localparam memLen_e FETCH_LEN = FOUR;

    // one 32-bit word, seen whole or as little-endian byte lanes
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lanes;
    } memWord_u;

endpackage

`default_nettype wire

/* hw/memSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystem (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_ioBufferFull,
    input  logic                      i_fetchEn,
    input  logic [memPkg::ADDR_W-1:0] i_fetchAddr,
    input  logic                      i_dataEn,
    input  logic                      i_dataStore,
    input  memPkg::memLen_e           i_dataLen,
    input  logic [memPkg::ADDR_W-1:0] i_dataAddr,
    input  logic [31:0]               i_dataWrite,
    output logic                      o_fetchDone,
    output logic [31:0]               o_fetchInst,
    output logic                      o_dataDone,
    output logic [31:0]               o_dataRead
);
    import memPkg::*;

    logic       accept;
    memKind_e   kind;
    logic       step;
    logic [1:0] byteIdx;
    logic [31:0] asmWord;

    ramPortIf ramPort ();

    memArbiter arbiter (
        .clk            (clk),
        .rst            (rst),
        .i_ioBufferFull (i_ioBufferFull),
        .i_fetchEn      (i_fetchEn),
        .i_dataEn       (i_dataEn),
        .i_dataStore    (i_dataStore),
        .i_dataLen      (i_dataLen),
        .o_accept       (accept),
        .o_kind         (kind),
        .o_step         (step),
        .o_byteIdx      (byteIdx),
        .o_fetchDone    (o_fetchDone),
        .o_dataDone     (o_dataDone)
    );

    byteSequencer sequencer (
        .clk         (clk),
        .rst         (rst),
        .i_accept    (accept),
        .i_kind      (kind),
        .i_step      (step),
        .i_byteIdx   (byteIdx),
        .i_fetchAddr (i_fetchAddr),
        .i_dataAddr  (i_dataAddr),
        .i_storeData (i_dataWrite),
        .port        (ramPort.seq)
    );

    byteAssembler assembler (
        .clk       (clk),
        .rst       (rst),
        .i_accept  (accept),
        .i_step    (step),
        .i_byteIdx (byteIdx),
        .port      (ramPort.mon),
        .o_word    (asmWord)
    );

    byteRam ram (
        .clk  (clk),
        .port (ramPort.ram)
    );

    // both results are only meaningful in their done cycle
    assign o_fetchInst = asmWord;
    assign o_dataRead  = asmWord;

endmodule

`default_nettype wire

/* hw/ramPortIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface ramPortIf;
    import memPkg::*;

    logic [ADDR_W-1:0] addr;
    logic              wrEn;
    logic [7:0]        wrData;
    // valid one cycle after addr
    logic [7:0]        rdData;

    modport seq (
        output addr,
        output wrEn,
        output wrData
    );

    modport ram (
        input  addr,
        input  wrEn,
        input  wrData,
        output rdData
    );

    modport mon (
        input rdData
    );

endinterface

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --timing -f tb.f --top-module memSubsystemTb -o memSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/memSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    exit 1
fi
exit 0

/* tb.f */
hw/memPkg.sv
hw/ramPortIf.sv
hw/memArbiter.sv
hw/byteSequencer.sv
hw/byteAssembler.sv
hw/byteRam.sv
hw/memSubsystem.sv
dv/memSubsystemTb.sv
